// File: logic/pg_pkg.sv
// Shared widths, timing constants, register map and register views for the port gasket
package pg_pkg;

   // --------------------
   // VF and FLR sizing
   // --------------------
   // Single PF with eight VFs below it
   localparam int MAX_VF   = 8;
   localparam int VF_NUM_W = 3;

   // VF reset hold time, counter sized to hold the full count
   localparam int FLR_HOLD_CYCLES = 16;
   localparam int FLR_CNT_W       = 5;

   // --------------------
   // Register bus
   // --------------------
   localparam int CSR_ADDR_W = 4;
   localparam int CSR_DATA_W = 64;

   // Word addresses
   localparam logic [CSR_ADDR_W-1:0] ADDR_DFH         = 4'h0;
   localparam logic [CSR_ADDR_W-1:0] ADDR_PORT_CTRL   = 4'h1;
   localparam logic [CSR_ADDR_W-1:0] ADDR_PORT_STATUS = 4'h2;
   localparam logic [CSR_ADDR_W-1:0] ADDR_SCRATCH     = 4'h3;

   // Port reset sequencer states
   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_DRAIN   = 2'd1,
      ST_HOLD    = 2'd2,
      ST_RELEASE = 2'd3
   } t_rst_state;

   // Which VF drives the reset of one port
   typedef struct packed {
      logic                vf_active;
      logic [VF_NUM_W-1:0] vf_num;
   } t_port_map;

   // Port control as software writes it
   typedef struct packed {
      logic [62:0] rsvd;
      logic        sw_reset_req;
   } t_port_ctrl_wr;

   // Port control as software reads it back
   typedef struct packed {
      logic [53:0] rsvd_hi;
      t_rst_state  state;
      logic [2:0]  rsvd_mid;
      logic        reset_ack;
      logic [2:0]  rsvd_lo;
      logic        sw_reset_req;
   } t_port_ctrl_rd;

   // One register word, two decodes
   typedef union packed {
      t_port_ctrl_wr wr;
      t_port_ctrl_rd rd;
   } t_port_ctrl;

endpackage

// File: logic/pg_ctrl_if.sv
// Control link between the port register block and the port reset sequencer
interface pg_ctrl_if
   import pg_pkg::*;
();

   // Software request for a port reset
   logic       sw_reset_req;

   // Sequencer has the slot in reset
   logic       reset_ack;

   // Soft reset into the accelerator slot
   logic       afu_softreset;

   // Current sequencer state, readable by software
   t_rst_state state;

   // Register block side
   modport csr (
      output sw_reset_req,
      input  reset_ack,
      input  state
   );

   // Sequencer side
   modport seq (
      input  sw_reset_req,
      output reset_ack,
      output afu_softreset,
      output state
   );

endinterface

// File: logic/flr_rst_mgr.sv
// FLR input stage: turns VF FLR request strobes into timed VF resets and completion strobes
module flr_rst_mgr
   import pg_pkg::*;
(
   input  logic                clk,
   input  logic                i_rst_n,

   // FLR request, one cycle per request
   input  logic                i_flr_req_valid,
   input  logic [VF_NUM_W-1:0] i_flr_req_vf,

   // Per-VF reset levels, active low
   output logic [MAX_VF-1:0]   o_vf_flr_rst_n,

   // FLR completion
   output logic                o_flr_rsp_valid,
   output logic [VF_NUM_W-1:0] o_flr_rsp_vf
);

   // One hold counter per VF, nonzero means in reset
   logic [FLR_CNT_W-1:0] hold_cnt [MAX_VF];

   logic                 req_accept;
   logic                 rsp_hit;
   logic [VF_NUM_W-1:0]  rsp_vf_d;

   // --------------------
   // Request acceptance
   // --------------------
   // Repeat request while the VF is held is dropped
   assign req_accept = i_flr_req_valid && (hold_cnt[i_flr_req_vf] == '0);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         for (int v = 0; v < MAX_VF; v++) begin
            hold_cnt[v] <= '0;
         end
      end else begin
         for (int v = 0; v < MAX_VF; v++) begin
            if (req_accept && (i_flr_req_vf == VF_NUM_W'(v))) begin
               hold_cnt[v] <= FLR_CNT_W'(FLR_HOLD_CYCLES);
            end else if (hold_cnt[v] != '0) begin
               hold_cnt[v] <= hold_cnt[v] - 1'b1;
            end
         end
      end
   end

   // VF reset straight from the counters
   always_comb begin
      for (int v = 0; v < MAX_VF; v++) begin
         o_vf_flr_rst_n[v] = (hold_cnt[v] == '0);
      end
   end

   // --------------------
   // Completion
   // --------------------
   // Counter about to hit zero
   // Equal hold lengths keep this to one VF per cycle
   always_comb begin
      rsp_hit  = 1'b0;
      rsp_vf_d = '0;
      for (int v = 0; v < MAX_VF; v++) begin
         if (hold_cnt[v] == FLR_CNT_W'(1)) begin
            rsp_hit  = 1'b1;
            rsp_vf_d = VF_NUM_W'(v);
         end
      end
   end

   // Strobe lines up with the reset release
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_flr_rsp_valid <= 1'b0;
      end else begin
         o_flr_rsp_valid <= rsp_hit;
      end
   end

   always_ff @(posedge clk) begin
      o_flr_rsp_vf <= rsp_vf_d;
   end

   // Completion only for a VF that was just held in reset
   a_rsp_after_hold: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      o_flr_rsp_valid |->
         (((MAX_VF'(1) << o_flr_rsp_vf) & ~$past(o_vf_flr_rst_n)) != '0)
   );

endmodule

// File: logic/pg_csr.sv
// Port register block: feature header, port control, VF reset status and scratch on a strobe bus
module pg_csr
   import pg_pkg::*;
#(
   parameter logic        END_OF_LIST     = 1'b0,
   parameter logic [23:0] NEXT_DFH_OFFSET = 24'h01_0000
) (
   input  logic                  clk,
   input  logic                  i_rst_n,

   // Register bus
   input  logic                  i_csr_wr,
   input  logic                  i_csr_rd,
   input  logic [CSR_ADDR_W-1:0] i_csr_addr,
   input  logic [CSR_DATA_W-1:0] i_csr_wdata,
   output logic [CSR_DATA_W-1:0] o_csr_rdata,
   output logic                  o_csr_rdata_valid,

   // VF reset levels for status
   input  logic [MAX_VF-1:0]     i_vf_flr_rst_n,

   // To the port reset sequencer
   pg_ctrl_if.csr                ctrl
);

   logic                  sw_reset_req_q;
   logic [CSR_DATA_W-1:0] scratch_q;
   logic [CSR_DATA_W-1:0] rdata_d;

   // Write and read decodes of port control
   t_port_ctrl            wr_word;
   t_port_ctrl            rd_word;

   assign wr_word = i_csr_wdata;

   // --------------------
   // Writes
   // --------------------
   // Unmapped addresses fall through
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         sw_reset_req_q <= 1'b0;
         scratch_q      <= '0;
      end else if (i_csr_wr) begin
         case (i_csr_addr)
            ADDR_PORT_CTRL: sw_reset_req_q <= wr_word.wr.sw_reset_req;
            ADDR_SCRATCH:   scratch_q      <= i_csr_wdata;
            default:        ;
         endcase
      end
   end

   assign ctrl.sw_reset_req = sw_reset_req_q;

   // Read view, reserved bits zero
   always_comb begin
      rd_word                 = '0;
      rd_word.rd.sw_reset_req = sw_reset_req_q;
      rd_word.rd.reset_ack    = ctrl.reset_ack;
      rd_word.rd.state        = ctrl.state;
   end

   // --------------------
   // Reads
   // --------------------
   always_comb begin
      rdata_d = '0;
      case (i_csr_addr)
         ADDR_DFH: begin
            rdata_d[23:0] = NEXT_DFH_OFFSET;
            rdata_d[40]   = END_OF_LIST;
         end
         ADDR_PORT_CTRL:   rdata_d = rd_word;
         // 1 means VF in reset
         ADDR_PORT_STATUS: rdata_d[MAX_VF-1:0] = ~i_vf_flr_rst_n;
         ADDR_SCRATCH:     rdata_d = scratch_q;
         default:          rdata_d = '0;
      endcase
   end

   // One cycle read latency
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_csr_rdata_valid <= 1'b0;
      end else begin
         o_csr_rdata_valid <= i_csr_rd;
      end
   end

   always_ff @(posedge clk) begin
      o_csr_rdata <= rdata_d;
   end

   // Bus master never mixes read and write
   a_no_rd_wr: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      !(i_csr_wr && i_csr_rd)
   );

endmodule

// File: logic/port_reset_fsm.sv
// Software port reset sequencer: waits for the slot to drain, holds it in reset, then releases it
module port_reset_fsm
   import pg_pkg::*;
(
   input  logic   clk,
   input  logic   i_rst_n,

   // Slot traffic has drained
   input  logic   i_drain_done,

   // Port soft reset, active low
   output logic   o_port_softreset_n,

   // From the register block
   pg_ctrl_if.seq ctrl
);

   t_rst_state state_q;
   t_rst_state state_d;
   logic       in_hold;

   // --------------------
   // State register
   // --------------------
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // --------------------
   // Next state
   // --------------------
   always_comb begin
      state_d = state_q;
      unique case (state_q)
         // Software asks for a reset
         ST_IDLE: begin
            if (ctrl.sw_reset_req) begin
               state_d = ST_DRAIN;
            end
         end
         // Wait for outstanding traffic
         // Time varies with the slot
         ST_DRAIN: begin
            if (i_drain_done) begin
               state_d = ST_HOLD;
            end
         end
         // Held until software clears the request
         ST_HOLD: begin
            if (!ctrl.sw_reset_req) begin
               state_d = ST_RELEASE;
            end
         end
         // One cycle with outputs already released
         ST_RELEASE: begin
            state_d = ST_IDLE;
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   // --------------------
   // Outputs
   // --------------------
   // Everything keyed off the hold state
   assign in_hold            = (state_q == ST_HOLD);
   assign ctrl.afu_softreset = in_hold;
   assign ctrl.reset_ack     = in_hold;
   assign ctrl.state         = state_q;
   assign o_port_softreset_n = ~in_hold;

   // Slot stays in reset while software still asks for it
   a_hold_while_req: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      ctrl.afu_softreset && ctrl.sw_reset_req |=> ctrl.afu_softreset
   );

   // Hold only after a completed drain
   a_hold_after_drain: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      (state_q == ST_HOLD) && ($past(state_q) != ST_HOLD) |->
         $past((state_q == ST_DRAIN) && i_drain_done)
   );

endmodule

// File: logic/port_rst_gen.sv
// Per-port reset generator: merges soft, PF and mapped VF resets and reports the port in FLR
module port_rst_gen
   import pg_pkg::*;
#(
   parameter int                         NUM_PORTS = 2,
   parameter t_port_map [NUM_PORTS-1:0]  PORT_MAP  = {NUM_PORTS{t_port_map'(0)}}
) (
   input  logic                         clk,
   input  logic                         i_rst_n,

   // Reset sources
   input  logic                         i_pf_flr_rst_n,
   input  logic                         i_afu_softreset,
   input  logic [MAX_VF-1:0]            i_vf_flr_rst_n,

   // Port resets, active low
   output logic [NUM_PORTS-1:0]         o_port_rst_n,

   // FLR sideband
   output logic                         o_flr_port_valid,
   output logic [$clog2(NUM_PORTS)-1:0] o_flr_port_num
);

   logic [NUM_PORTS-1:0] func_vf_rst_n;
   logic [NUM_PORTS-1:0] vf_rst_q;

   // --------------------
   // Per-port reset
   // --------------------
   for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
      // Unmapped port ignores VF resets
      assign func_vf_rst_n[p] = PORT_MAP[p].vf_active ?
                                i_vf_flr_rst_n[PORT_MAP[p].vf_num] : 1'b1;

      // System reset is one of the sources, so it stays low one cycle past reset
      always_ff @(posedge clk) begin
         o_port_rst_n[p] <= ~i_afu_softreset & i_pf_flr_rst_n & func_vf_rst_n[p] & i_rst_n;
      end
   end

   // Marks ports whose reset comes from their VF
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         vf_rst_q <= '0;
      end else begin
         vf_rst_q <= ~func_vf_rst_n;
      end
   end

   // Highest port in VF reset wins
   always_comb begin
      o_flr_port_valid = 1'b0;
      o_flr_port_num   = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (vf_rst_q[p] && !o_port_rst_n[p]) begin
            o_flr_port_valid = 1'b1;
            o_flr_port_num   = ($clog2(NUM_PORTS))'(p);
         end
      end
   end

endmodule

// File: logic/port_gasket.sv
// Port gasket top: wires FLR handling, registers, reset sequencer and port reset outputs together
module port_gasket
   import pg_pkg::*;
#(
   parameter int                        NUM_PORTS       = 2,
   parameter t_port_map [NUM_PORTS-1:0] PORT_MAP        = {NUM_PORTS{t_port_map'(0)}},
   parameter logic                      END_OF_LIST     = 1'b0,
   parameter logic [23:0]               NEXT_DFH_OFFSET = 24'h01_0000
) (
   input  logic                         clk,
   input  logic                         i_rst_n,

   // FLR requests and completions
   input  logic                         i_flr_req_valid,
   input  logic [VF_NUM_W-1:0]          i_flr_req_vf,
   output logic                         o_flr_rsp_valid,
   output logic [VF_NUM_W-1:0]          o_flr_rsp_vf,
   input  logic                         i_pf_flr_rst_n,

   // Register bus
   input  logic                         i_csr_wr,
   input  logic                         i_csr_rd,
   input  logic [CSR_ADDR_W-1:0]        i_csr_addr,
   input  logic [CSR_DATA_W-1:0]        i_csr_wdata,
   output logic [CSR_DATA_W-1:0]        o_csr_rdata,
   output logic                         o_csr_rdata_valid,

   // Slot reset control
   input  logic                         i_drain_done,
   output logic                         o_port_softreset_n,
   output logic                         o_afu_softreset,

   // Port resets and FLR sideband
   output logic [NUM_PORTS-1:0]         o_port_rst_n,
   output logic                         o_flr_port_valid,
   output logic [$clog2(NUM_PORTS)-1:0] o_flr_port_num
);

   logic [MAX_VF-1:0] vf_flr_rst_n;

   pg_ctrl_if ctrl_if ();

   assign o_afu_softreset = ctrl_if.afu_softreset;

   // --------------------
   // FLR input side
   // --------------------
   flr_rst_mgr u_flr_rst_mgr (
      .clk             (clk),
      .i_rst_n         (i_rst_n),
      .i_flr_req_valid (i_flr_req_valid),
      .i_flr_req_vf    (i_flr_req_vf),
      .o_vf_flr_rst_n  (vf_flr_rst_n),
      .o_flr_rsp_valid (o_flr_rsp_valid),
      .o_flr_rsp_vf    (o_flr_rsp_vf)
   );

   // --------------------
   // Registers and sequencer
   // --------------------
   pg_csr #(
      .END_OF_LIST     (END_OF_LIST),
      .NEXT_DFH_OFFSET (NEXT_DFH_OFFSET)
   ) u_pg_csr (
      .clk               (clk),
      .i_rst_n           (i_rst_n),
      .i_csr_wr          (i_csr_wr),
      .i_csr_rd          (i_csr_rd),
      .i_csr_addr        (i_csr_addr),
      .i_csr_wdata       (i_csr_wdata),
      .o_csr_rdata       (o_csr_rdata),
      .o_csr_rdata_valid (o_csr_rdata_valid),
      .i_vf_flr_rst_n    (vf_flr_rst_n),
      .ctrl              (ctrl_if.csr)
   );

   port_reset_fsm u_port_reset_fsm (
      .clk                (clk),
      .i_rst_n            (i_rst_n),
      .i_drain_done       (i_drain_done),
      .o_port_softreset_n (o_port_softreset_n),
      .ctrl               (ctrl_if.seq)
   );

   // --------------------
   // Port reset output side
   // --------------------
   port_rst_gen #(
      .NUM_PORTS (NUM_PORTS),
      .PORT_MAP  (PORT_MAP)
   ) u_port_rst_gen (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .i_pf_flr_rst_n   (i_pf_flr_rst_n),
      .i_afu_softreset  (ctrl_if.afu_softreset),
      .i_vf_flr_rst_n   (vf_flr_rst_n),
      .o_port_rst_n     (o_port_rst_n),
      .o_flr_port_valid (o_flr_port_valid),
      .o_flr_port_num   (o_flr_port_num)
   );

endmodule

// File: testbench/tb_port_gasket.sv
// Self-checking testbench for the port gasket, run as the simulation top with the file list
module tb_port_gasket
   import pg_pkg::*;
();

   localparam int              CLK_PERIOD     = 100;
   localparam int              RST_CYCLES     = 10;
   localparam int              DRIVE_DELAY    = 10;
   localparam logic            TB_END_OF_LIST = 1'b1;
   localparam logic [23:0]     TB_NEXT_DFH    = 24'h00_2000;
   // Port 1 on VF 5, port 0 on VF 2
   localparam t_port_map [1:0] TB_PORT_MAP    = {t_port_map'{1'b1, 3'd5},
                                                 t_port_map'{1'b1, 3'd2}};

   // Test lengths in cycles, watchdog adds a margin
   localparam int LEN_REGS        = 24;
   localparam int LEN_SINGLE      = FLR_HOLD_CYCLES + 12;
   localparam int LEN_OVERLAP     = 3 * FLR_HOLD_CYCLES + 16;
   localparam int LEN_PF          = 16;
   localparam int LEN_SOFT        = 48;
   localparam int WATCHDOG_CYCLES = RST_CYCLES + LEN_REGS + LEN_SINGLE + LEN_OVERLAP +
                                    LEN_PF + LEN_SOFT + 100;

   logic                  clk;
   logic                  rst_n;
   logic                  flr_req_valid;
   logic [VF_NUM_W-1:0]   flr_req_vf;
   logic                  pf_flr_rst_n;
   logic                  csr_wr;
   logic                  csr_rd;
   logic [CSR_ADDR_W-1:0] csr_addr;
   logic [CSR_DATA_W-1:0] csr_wdata;
   logic                  drain_done;
   logic                  flr_rsp_valid;
   logic [VF_NUM_W-1:0]   flr_rsp_vf;
   logic [CSR_DATA_W-1:0] csr_rdata;
   logic                  csr_rdata_valid;
   logic                  port_softreset_n;
   logic                  afu_softreset;
   logic [1:0]            port_rst_n;
   logic                  flr_port_valid;
   logic                  flr_port_num;

   // Reference model state
   logic [FLR_CNT_W-1:0]  vf_cnt [MAX_VF];
   logic [MAX_VF-1:0]     vf_in_rst;
   logic [MAX_VF-1:0]     vf_in_rst_q;
   logic [1:0]            port_vf_hit;
   logic                  exp_rsp_valid;
   logic [VF_NUM_W-1:0]   exp_rsp_vf;
   logic                  exp_req;
   t_rst_state            exp_state;
   logic                  exp_hold;
   logic [1:0]            exp_port_rst_n;
   logic [1:0]            exp_port_vf;
   logic                  exp_fp_valid;
   logic                  exp_fp_num;
   logic                  exp_rd_valid;
   logic [CSR_DATA_W-1:0] exp_rdata;
   logic [CSR_DATA_W-1:0] exp_scratch;

   logic [15:0]           lfsr;
   int                    err_cnt;
   int                    tests_run;

   port_gasket #(
      .NUM_PORTS       (2),
      .PORT_MAP        (TB_PORT_MAP),
      .END_OF_LIST     (TB_END_OF_LIST),
      .NEXT_DFH_OFFSET (TB_NEXT_DFH)
   ) dut (
      .clk                (clk),
      .i_rst_n            (rst_n),
      .i_flr_req_valid    (flr_req_valid),
      .i_flr_req_vf       (flr_req_vf),
      .o_flr_rsp_valid    (flr_rsp_valid),
      .o_flr_rsp_vf       (flr_rsp_vf),
      .i_pf_flr_rst_n     (pf_flr_rst_n),
      .i_csr_wr           (csr_wr),
      .i_csr_rd           (csr_rd),
      .i_csr_addr         (csr_addr),
      .i_csr_wdata        (csr_wdata),
      .o_csr_rdata        (csr_rdata),
      .o_csr_rdata_valid  (csr_rdata_valid),
      .i_drain_done       (drain_done),
      .o_port_softreset_n (port_softreset_n),
      .o_afu_softreset    (afu_softreset),
      .o_port_rst_n       (port_rst_n),
      .o_flr_port_valid   (flr_port_valid),
      .o_flr_port_num     (flr_port_num)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // --------------------
   // Helpers
   // --------------------
   // Taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit drawn
   function automatic int rand_bits(input int n);
      int val;
      val = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         val  = (val << 1) | int'(lfsr[0]);
      end
      return val;
   endfunction

   function automatic void report_mismatch(input string name, input logic [63:0] got,
                                           input logic [63:0] exp);
      $display("ERR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      err_cnt++;
   endfunction

   // Register word as the map defines it, from current model state
   function automatic logic [CSR_DATA_W-1:0] expected_read(input logic [CSR_ADDR_W-1:0] addr);
      logic [CSR_DATA_W-1:0] val;
      val = '0;
      case (addr)
         ADDR_DFH: begin
            val[23:0] = TB_NEXT_DFH;
            val[40]   = TB_END_OF_LIST;
         end
         ADDR_PORT_CTRL: begin
            val[0]   = exp_req;
            val[4]   = exp_hold;
            val[9:8] = exp_state;
         end
         ADDR_PORT_STATUS: val[MAX_VF-1:0] = vf_in_rst;
         ADDR_SCRATCH:     val = exp_scratch;
         default:          val = '0;
      endcase
      return val;
   endfunction

   // --------------------
   // Reference model
   // --------------------
   always_comb begin
      exp_rsp_valid = 1'b0;
      exp_rsp_vf    = '0;
      for (int v = 0; v < MAX_VF; v++) begin
         vf_in_rst[v] = (vf_cnt[v] != '0);
         // Completion in the cycle the VF leaves reset
         if (vf_in_rst_q[v] && !vf_in_rst[v]) begin
            exp_rsp_valid = 1'b1;
            exp_rsp_vf    = VF_NUM_W'(v);
         end
      end
      exp_hold     = (exp_state == ST_HOLD);
      exp_fp_valid = 1'b0;
      exp_fp_num   = 1'b0;
      for (int p = 0; p < 2; p++) begin
         port_vf_hit[p] = TB_PORT_MAP[p].vf_active && vf_in_rst[TB_PORT_MAP[p].vf_num];
         // Highest port held by its VF
         if (exp_port_vf[p] && !exp_port_rst_n[p]) begin
            exp_fp_valid = 1'b1;
            exp_fp_num   = 1'(p);
         end
      end
   end

   always @(posedge clk) begin
      if (!rst_n) begin
         for (int v = 0; v < MAX_VF; v++) begin
            vf_cnt[v] <= '0;
         end
         vf_in_rst_q  <= '0;
         exp_req      <= 1'b0;
         exp_state    <= ST_IDLE;
         exp_port_vf  <= '0;
         exp_rd_valid <= 1'b0;
         exp_scratch  <= '0;
      end else begin
         // Hold counts, a request during a hold is dropped
         for (int v = 0; v < MAX_VF; v++) begin
            if (flr_req_valid && (flr_req_vf == VF_NUM_W'(v)) && !vf_in_rst[v]) begin
               vf_cnt[v] <= FLR_CNT_W'(FLR_HOLD_CYCLES);
            end else if (vf_in_rst[v]) begin
               vf_cnt[v] <= vf_cnt[v] - 1'b1;
            end
         end
         vf_in_rst_q <= vf_in_rst;
         if (csr_wr && (csr_addr == ADDR_PORT_CTRL)) begin
            exp_req <= csr_wdata[0];
         end
         if (csr_wr && (csr_addr == ADDR_SCRATCH)) begin
            exp_scratch <= csr_wdata;
         end
         // Request, drain, hold, release
         case (exp_state)
            ST_IDLE:  if (exp_req) exp_state <= ST_DRAIN;
            ST_DRAIN: if (drain_done) exp_state <= ST_HOLD;
            ST_HOLD:  if (!exp_req) exp_state <= ST_RELEASE;
            default:  exp_state <= ST_IDLE;
         endcase
         exp_port_vf  <= port_vf_hit;
         exp_rd_valid <= csr_rd;
      end
      exp_rdata      <= expected_read(csr_addr);
      exp_port_rst_n <= {2{!exp_hold && pf_flr_rst_n && rst_n}} & ~port_vf_hit;
   end

   // --------------------
   // Checks
   // --------------------
   chk_rsp_valid: assert property (@(posedge clk) disable iff (!rst_n)
      flr_rsp_valid == exp_rsp_valid)
      else report_mismatch("o_flr_rsp_valid", 64'($sampled(flr_rsp_valid)),
                           64'($sampled(exp_rsp_valid)));

   chk_rsp_vf: assert property (@(posedge clk) disable iff (!rst_n)
      flr_rsp_valid |-> (flr_rsp_vf == exp_rsp_vf))
      else report_mismatch("o_flr_rsp_vf", 64'($sampled(flr_rsp_vf)), 64'($sampled(exp_rsp_vf)));

   chk_port_rst: assert property (@(posedge clk) disable iff (!rst_n)
      port_rst_n == exp_port_rst_n)
      else report_mismatch("o_port_rst_n", 64'($sampled(port_rst_n)),
                           64'($sampled(exp_port_rst_n)));

   chk_fp_valid: assert property (@(posedge clk) disable iff (!rst_n)
      flr_port_valid == exp_fp_valid)
      else report_mismatch("o_flr_port_valid", 64'($sampled(flr_port_valid)),
                           64'($sampled(exp_fp_valid)));

   chk_fp_num: assert property (@(posedge clk) disable iff (!rst_n)
      flr_port_valid |-> (flr_port_num == exp_fp_num))
      else report_mismatch("o_flr_port_num", 64'($sampled(flr_port_num)),
                           64'($sampled(exp_fp_num)));

   chk_afu_soft: assert property (@(posedge clk) disable iff (!rst_n)
      afu_softreset == exp_hold)
      else report_mismatch("o_afu_softreset", 64'($sampled(afu_softreset)),
                           64'($sampled(exp_hold)));

   chk_port_soft: assert property (@(posedge clk) disable iff (!rst_n)
      port_softreset_n == !exp_hold)
      else report_mismatch("o_port_softreset_n", 64'($sampled(port_softreset_n)),
                           64'(!$sampled(exp_hold)));

   chk_rd_valid: assert property (@(posedge clk) disable iff (!rst_n)
      csr_rdata_valid == exp_rd_valid)
      else report_mismatch("o_csr_rdata_valid", 64'($sampled(csr_rdata_valid)),
                           64'($sampled(exp_rd_valid)));

   chk_rdata: assert property (@(posedge clk) disable iff (!rst_n)
      csr_rdata_valid |-> (csr_rdata == exp_rdata))
      else report_mismatch("o_csr_rdata", $sampled(csr_rdata), $sampled(exp_rdata));

   // --------------------
   // Stimulus tasks
   // --------------------
   // Lands just after the edge, where inputs change
   task automatic tick(input int n);
      repeat (n) begin
         @(posedge clk);
         #DRIVE_DELAY;
      end
   endtask

   task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr,
                            input logic [CSR_DATA_W-1:0] data);
      csr_wr    = 1'b1;
      csr_addr  = addr;
      csr_wdata = data;
      tick(1);
      csr_wr    = 1'b0;
   endtask

   task automatic csr_read(input logic [CSR_ADDR_W-1:0] addr);
      int n;
      csr_rd   = 1'b1;
      csr_addr = addr;
      tick(1);
      csr_rd   = 1'b0;
      n        = 0;
      while (!csr_rdata_valid && (n < 4)) begin
         tick(1);
         n++;
      end
      if (!csr_rdata_valid) begin
         $display("Read of address %0d returned no read data", addr);
         err_cnt++;
      end
   endtask

   task automatic flr_request(input logic [VF_NUM_W-1:0] vf);
      flr_req_valid = 1'b1;
      flr_req_vf    = vf;
      tick(1);
      flr_req_valid = 1'b0;
   endtask

   // Steps past the strobe so the next wait sees a fresh one
   task automatic wait_flr_rsp(input int limit);
      int n;
      n = 0;
      while (!flr_rsp_valid && (n < limit)) begin
         tick(1);
         n++;
      end
      if (!flr_rsp_valid) begin
         $display("No FLR response within %0d cycles", limit);
         err_cnt++;
      end
      tick(1);
   endtask

   task automatic wait_ports(input logic [1:0] level, input int limit);
      int n;
      n = 0;
      while ((port_rst_n != level) && (n < limit)) begin
         tick(1);
         n++;
      end
      if (port_rst_n != level) begin
         $display("Port resets stuck at %b, waiting for %b", port_rst_n, level);
         err_cnt++;
      end
   endtask

   task automatic wait_softreset(input logic level, input int limit);
      int n;
      n = 0;
      while ((afu_softreset != level) && (n < limit)) begin
         tick(1);
         n++;
      end
      if (afu_softreset != level) begin
         $display("Slot soft reset never went to %0d", level);
         err_cnt++;
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests_run++;
      $display("test %-16s finished, %0d errors", name, err_cnt - errs_before);
   endtask

   // --------------------
   // Tests
   // --------------------
   task automatic test_registers();
      int                    errs;
      logic [CSR_DATA_W-1:0] pattern;
      errs    = err_cnt;
      pattern = {32'(rand_bits(32)), 32'(rand_bits(32))};
      csr_read(ADDR_DFH);
      csr_write(ADDR_SCRATCH, pattern);
      csr_read(ADDR_SCRATCH);
      // Unmapped write must not land anywhere
      csr_write(4'hB, ~pattern);
      csr_read(4'hB);
      csr_read(4'h7);
      csr_read(ADDR_SCRATCH);
      finish_test("registers", errs);
   endtask

   task automatic test_single_flr();
      int                  errs;
      logic [VF_NUM_W-1:0] vf;
      errs = err_cnt;
      vf   = VF_NUM_W'(rand_bits(VF_NUM_W));
      flr_request(vf);
      tick(2);
      // Status mid hold
      csr_read(ADDR_PORT_STATUS);
      wait_flr_rsp(FLR_HOLD_CYCLES + 4);
      tick(2);
      finish_test("single VF FLR", errs);
   endtask

   task automatic test_overlap_flr();
      int errs;
      errs = err_cnt;
      flr_request(3'd2);
      tick(1 + rand_bits(2));
      flr_request(3'd5);
      tick(2);
      // Repeat while VF 2 still held
      flr_request(3'd2);
      wait_flr_rsp(FLR_HOLD_CYCLES + 4);
      wait_flr_rsp(FLR_HOLD_CYCLES);
      // Room for a stray completion
      tick(FLR_HOLD_CYCLES);
      finish_test("overlapping FLR", errs);
   endtask

   task automatic test_pf_flr();
      int errs;
      errs         = err_cnt;
      pf_flr_rst_n = 1'b0;
      wait_ports(2'b00, 4);
      tick(3);
      pf_flr_rst_n = 1'b1;
      wait_ports(2'b11, 4);
      tick(2);
      finish_test("PF FLR", errs);
   endtask

   task automatic test_soft_reset();
      int errs;
      int delay;
      errs  = err_cnt;
      delay = 2 + rand_bits(4);
      csr_write(ADDR_PORT_CTRL, 64'd1);
      // Slot still draining
      tick(delay);
      drain_done = 1'b1;
      wait_softreset(1'b1, 8);
      drain_done = 1'b0;
      csr_read(ADDR_PORT_CTRL);
      tick(2);
      csr_write(ADDR_PORT_CTRL, 64'd0);
      wait_softreset(1'b0, 4);
      tick(2);
      csr_read(ADDR_PORT_CTRL);
      finish_test("software reset", errs);
   endtask

   // --------------------
   // Main sequence
   // --------------------
   initial begin
      rst_n         = 1'b0;
      flr_req_valid = 1'b0;
      flr_req_vf    = '0;
      pf_flr_rst_n  = 1'b1;
      csr_wr        = 1'b0;
      csr_rd        = 1'b0;
      csr_addr      = '0;
      csr_wdata     = '0;
      drain_done    = 1'b0;
      lfsr          = 16'd54187;
      err_cnt       = 0;
      tests_run     = 0;
      tick(RST_CYCLES);
      rst_n = 1'b1;
      tick(2);
      test_registers();
      test_single_flr();
      test_overlap_flr();
      test_pf_flr();
      test_soft_reset();
      $display("%0d tests run, %0d check failures", tests_run, err_cnt);
      if (err_cnt == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // Hang guard
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
      $display("Regression failed");
      $finish;
   end

endmodule

// File: port_gasket.f
logic/pg_pkg.sv
logic/pg_ctrl_if.sv
logic/flr_rst_mgr.sv
logic/pg_csr.sv
logic/port_reset_fsm.sv
logic/port_rst_gen.sv
logic/port_gasket.sv
testbench/tb_port_gasket.sv

// File: Makefile
# Verilator build and regression run for the port gasket

TOP = tb_port_gasket

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f port_gasket.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
